/* capture_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared widths and types for the trace capture unit
// imported by wildcard in each module header that needs them
//////////////////////////////////////////////////////////////////////

package capture_pkg;

	//////////////////////////////////////////////////////////////////////
	// sensor geometry
	//////////////////////////////////////////////////////////////////////

	// width of the carry chain adder
	localparam int CHAIN_W = 128;

	// copies of the parameter byte needed to fill one operand
	localparam int SENSOR_REPS = CHAIN_W / 8;

	//////////////////////////////////////////////////////////////////////
	// data types
	//////////////////////////////////////////////////////////////////////

	// uart data, parameter byte and sample values
	typedef logic [7:0] byte_t;

	// one adder operand or sum
	typedef logic [CHAIN_W-1:0] chain_t;

	// controller FSM states
	typedef enum logic [2:0]
	{
		// waiting for a parameter byte
		IDLE       = 3'd0,
		// one sensor request per cycle
		SAMPLE     = 3'd1,
		// last two samples still in the sensor pipe
		DRAIN      = 3'd2,
		// quiet time before the dump
		GAP        = 3'd3,
		// echo of the parameter byte
		SEND_PARAM = 3'd4,
		// next trace byte out of the memory
		SEND_TRACE = 3'd5,
		// byte on the line, wait for the transmitter
		WAIT_TX    = 3'd6
	} ctrl_state_t;

endpackage

/* uart_rx.sv */
//////////////////////////////////////////////////////////////////////
// 8N1 uart receiver for the capture trigger byte
// rx_valid pulses for one cycle in the middle of a good stop bit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module uart_rx import capture_pkg::*;
#(
	parameter int CLKS_PER_BIT = 434
)
(
	input  logic  clk0,
	input  logic  c10_resetn,
	input  logic  rx,
	output byte_t rx_data,
	output logic  rx_valid
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	typedef enum logic [1:0]
	{
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t        state;
	logic             rx_meta;
	logic             rx_s;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;

	// two flop synchronizer, line idles high
	always_ff @(posedge clk0 or negedge c10_resetn)
	begin
		if (!c10_resetn)
		begin
			rx_meta <= 1'b1;
			rx_s    <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_s    <= rx_meta;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// bit timing, sample at mid-bit
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk0 or negedge c10_resetn)
	begin
		if (!c10_resetn)
		begin
			state    <= RX_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
			rx_data  <= '0;
		end
		else
		begin
			rx_valid <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					clk_cnt <= '0;
					// falling edge = start bit
					if (!rx_s)
						state <= RX_START;
				end
				RX_START:
				begin
					if (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1))
					begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// glitch check, still low at mid start bit
						state   <= rx_s ? RX_IDLE : RX_DATA;
					end
					else
						clk_cnt <= clk_cnt + 1'b1;
				end
				RX_DATA:
				begin
					if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1))
					begin
						clk_cnt <= '0;
						// lsb first, shifts in from the top
						rx_data <= {rx_s, rx_data[7:1]};
						if (bit_idx == 3'd7)
							state <= RX_STOP;
						else
							bit_idx <= bit_idx + 1'b1;
					end
					else
						clk_cnt <= clk_cnt + 1'b1;
				end
				default:
				begin
					if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1))
					begin
						// framing error drops the byte
						rx_valid <= rx_s;
						state    <= RX_IDLE;
					end
					else
						clk_cnt <= clk_cnt + 1'b1;
				end
			endcase
		end
	end

endmodule

/* uart_tx.sv */
//////////////////////////////////////////////////////////////////////
// 8N1 uart transmitter for the trace dump
// a byte is taken when tx_start and tx_ready are both high
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module uart_tx import capture_pkg::*;
#(
	parameter int CLKS_PER_BIT = 434
)
(
	input  logic  clk0,
	input  logic  c10_resetn,
	input  byte_t tx_data,
	input  logic  tx_start,
	output logic  tx_ready,
	output logic  tx
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	// stop, data lsb first, start, shifted out from bit 0
	logic [9:0]       shreg;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_idx;

	// line level is always the low end of the shifter
	assign tx = shreg[0];

	always_ff @(posedge clk0 or negedge c10_resetn)
	begin
		if (!c10_resetn)
		begin
			shreg    <= '1;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			tx_ready <= 1'b1;
		end
		else if (tx_ready)
		begin
			clk_cnt <= '0;
			bit_idx <= '0;
			if (tx_start)
			begin
				shreg    <= {1'b1, tx_data, 1'b0};
				tx_ready <= 1'b0;
			end
		end
		else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1))
		begin
			clk_cnt <= '0;
			// ones fill from the top, line rests high afterwards
			shreg   <= {1'b1, shreg[9:1]};
			// end of stop bit, ready again
			if (bit_idx == 4'd9)
				tx_ready <= 1'b1;
			else
				bit_idx <= bit_idx + 1'b1;
		end
		else
			clk_cnt <= clk_cnt + 1'b1;
	end

endmodule

/* carry_sensor.sv */
//////////////////////////////////////////////////////////////////////
// carry chain sensor with one wide adder fed from the parameter byte
// two cycle pipe of a sum register and a trailing ones count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module carry_sensor import capture_pkg::*;
(
	input  logic  clk0,
	input  logic  c10_resetn,
	input  byte_t param,
	input  logic  sample_req,
	input  logic  sample_parity,
	output logic  sample_valid,
	output byte_t sample_data
);

	chain_t pattern;
	chain_t operand_a;
	chain_t operand_b;
	chain_t sum_q;
	logic   req_q;

	// thermometer decode counts ones up from bit 0
	function automatic byte_t trailing_ones(input chain_t s);
		byte_t n;
		logic  run;
		n   = '0;
		run = 1'b1;
		for (int i = 0; i < CHAIN_W; i++)
		begin
			if (run && s[i])
				n = n + 8'd1;
			else
				run = 1'b0;
		end
		return n;
	endfunction

	assign pattern   = {SENSOR_REPS{param}};
	assign operand_a = ~pattern;
	// parity stands in for the clock on the carry-in bit
	assign operand_b = {pattern[CHAIN_W-2:0], sample_parity};

	// stage one sum and stage two trailing ones count
	always_ff @(posedge clk0)
	begin
		sum_q       <= operand_a + operand_b;
		sample_data <= trailing_ones(sum_q);
	end

	// valid follows the request through both stages
	always_ff @(posedge clk0 or negedge c10_resetn)
	begin
		if (!c10_resetn)
		begin
			req_q        <= 1'b0;
			sample_valid <= 1'b0;
		end
		else
		begin
			req_q        <= sample_req;
			sample_valid <= req_q;
		end
	end

endmodule

/* trace_ram.sv */
//////////////////////////////////////////////////////////////////////
// trace memory for one capture run
// single port, write and read share addr, read data one cycle later
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module trace_ram import capture_pkg::*;
#(
	parameter  int SAMPLES = 1024,
	localparam int ADDR_W  = $clog2(SAMPLES)
)
(
	input  logic              clk0,
	input  logic              we,
	input  logic [ADDR_W-1:0] addr,
	input  byte_t             wdata,
	output byte_t             rdata
);

	// one byte per sample
	byte_t mem [SAMPLES];

	always_ff @(posedge clk0)
	begin
		if (we)
			mem[addr] <= wdata;
		// registered read
		rdata <= mem[addr];
	end

endmodule

/* capture_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// capture controller FSM
// trigger on a received byte, fill the trace, wait, then dump it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module capture_ctrl import capture_pkg::*;
#(
	parameter  int SAMPLES    = 1024,
	parameter  int GAP_CYCLES = 200,
	localparam int ADDR_W     = $clog2(SAMPLES)
)
(
	input  logic              clk0,
	input  logic              c10_resetn,
	input  byte_t             rx_data,
	input  logic              rx_valid,
	output byte_t             param,
	output logic              sample_req,
	output logic              sample_parity,
	input  logic              sample_valid,
	input  byte_t             sample_data,
	output logic              we,
	output logic [ADDR_W-1:0] addr,
	output byte_t             wdata,
	input  byte_t             rdata,
	output byte_t             tx_data,
	output logic              tx_start,
	input  logic              tx_ready,
	output logic              capture_active
);

	localparam int WAIT_W = $clog2(GAP_CYCLES + 1);

	ctrl_state_t       state;
	logic [ADDR_W-1:0] req_cnt;
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic [WAIT_W-1:0] wait_cnt;
	// set once the final trace byte is handed over
	logic              last_q;

	//////////////////////////////////////////////////////////////////////
	// sensor and memory side
	//////////////////////////////////////////////////////////////////////

	assign sample_req     = (state == SAMPLE);
	// request k carries parity of k
	assign sample_parity  = req_cnt[0];
	assign capture_active = (state != IDLE);

	// samples land straight in the trace
	assign we    = sample_valid;
	assign wdata = sample_data;
	// write pointer while filling, read pointer for the dump
	assign addr  = (state == SAMPLE || state == DRAIN) ? wr_ptr : rd_ptr;

	// write pointer runs behind the requests by the sensor latency
	always_ff @(posedge clk0 or negedge c10_resetn)
	begin
		if (!c10_resetn)
			wr_ptr <= '0;
		else if (state == IDLE)
			wr_ptr <= '0;
		else if (sample_valid)
			wr_ptr <= wr_ptr + 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// main FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk0 or negedge c10_resetn)
	begin
		if (!c10_resetn)
		begin
			state    <= IDLE;
			req_cnt  <= '0;
			rd_ptr   <= '0;
			wait_cnt <= '0;
			last_q   <= 1'b0;
			tx_start <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					req_cnt  <= '0;
					rd_ptr   <= '0;
					wait_cnt <= '0;
					last_q   <= 1'b0;
					// trigger byte, anything later is ignored
					if (rx_valid)
						state <= SAMPLE;
				end
				SAMPLE:
				begin
					req_cnt <= req_cnt + 1'b1;
					if (req_cnt == ADDR_W'(SAMPLES - 1))
						state <= DRAIN;
				end
				DRAIN:
				begin
					// two cycles for the last samples to land
					if (wait_cnt == WAIT_W'(1))
					begin
						wait_cnt <= '0;
						state    <= GAP;
					end
					else
						wait_cnt <= wait_cnt + 1'b1;
				end
				GAP:
				begin
					if (wait_cnt == WAIT_W'(GAP_CYCLES - 1))
						state <= SEND_PARAM;
					else
						wait_cnt <= wait_cnt + 1'b1;
				end
				SEND_PARAM:
				begin
					// echo first, rdata of entry 0 settles meanwhile
					if (tx_ready)
					begin
						tx_data  <= param;
						tx_start <= 1'b1;
						state    <= WAIT_TX;
					end
				end
				SEND_TRACE:
				begin
					if (tx_ready)
					begin
						tx_data  <= rdata;
						tx_start <= 1'b1;
						last_q   <= (rd_ptr == ADDR_W'(SAMPLES - 1));
						rd_ptr   <= rd_ptr + 1'b1;
						state    <= WAIT_TX;
					end
				end
				WAIT_TX:
				begin
					// first cycle the byte is taken, ready drops after
					if (tx_start)
						tx_start <= 1'b0;
					else if (tx_ready)
						state <= last_q ? IDLE : SEND_TRACE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// param byte held for the whole run
	always_ff @(posedge clk0)
	begin
		if (state == IDLE && rx_valid)
			param <= rx_data;
	end

endmodule

/* capture_top.sv */
//////////////////////////////////////////////////////////////////////
// top level of the trace capture unit
// uart in, carry chain sensor, trace memory, uart out
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module capture_top import capture_pkg::*;
#(
	parameter int CLKS_PER_BIT = 434,
	parameter int SAMPLES      = 1024,
	parameter int GAP_CYCLES   = 200
)
(
	input  logic clk0,
	input  logic c10_resetn,
	input  logic rx,
	output logic tx,
	output logic capture_active
);

	localparam int ADDR_W = $clog2(SAMPLES);

	// uart links
	byte_t rx_data;
	logic  rx_valid;
	byte_t tx_data;
	logic  tx_start;
	logic  tx_ready;

	// sensor link
	byte_t param;
	logic  sample_req;
	logic  sample_parity;
	logic  sample_valid;
	byte_t sample_data;

	// trace memory port
	logic              we;
	logic [ADDR_W-1:0] addr;
	byte_t             wdata;
	byte_t             rdata;

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx
	(
		.clk0(clk0), .c10_resetn(c10_resetn), .rx(rx),
		.rx_data(rx_data), .rx_valid(rx_valid)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx
	(
		.clk0(clk0), .c10_resetn(c10_resetn), .tx_data(tx_data),
		.tx_start(tx_start), .tx_ready(tx_ready), .tx(tx)
	);

	carry_sensor u_carry_sensor
	(
		.clk0(clk0), .c10_resetn(c10_resetn), .param(param),
		.sample_req(sample_req), .sample_parity(sample_parity),
		.sample_valid(sample_valid), .sample_data(sample_data)
	);

	trace_ram #(.SAMPLES(SAMPLES)) u_trace_ram
	(
		.clk0(clk0), .we(we), .addr(addr), .wdata(wdata), .rdata(rdata)
	);

	capture_ctrl #(.SAMPLES(SAMPLES), .GAP_CYCLES(GAP_CYCLES)) u_capture_ctrl
	(
		.clk0(clk0), .c10_resetn(c10_resetn),
		.rx_data(rx_data), .rx_valid(rx_valid),
		.param(param), .sample_req(sample_req), .sample_parity(sample_parity),
		.sample_valid(sample_valid), .sample_data(sample_data),
		.we(we), .addr(addr), .wdata(wdata), .rdata(rdata),
		.tx_data(tx_data), .tx_start(tx_start), .tx_ready(tx_ready),
		.capture_active(capture_active)
	);

endmodule

/* capture_tb.sv */
//////////////////////////////////////////////////////////////////////
// self-checking testbench for the trace capture unit
// reads capture_cases.txt, triggers one capture per line, checks the dump
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module capture_tb import capture_pkg::*;
();

	localparam int BIT_CLKS     = 8;
	localparam int SAMPLES      = 16;
	localparam int GAP_CYCLES   = 20;
	localparam int SEED         = 32'h5e3c_cd1c;
	// start bit search covers sample and gap time
	localparam int RX_LIMIT     = 2000;
	// capture_active drops right after the last stop bit
	localparam int DROP_LIMIT   = 4 * BIT_CLKS;
	// long enough to see a second frame start
	localparam int QUIET_CYCLES = 400;
	localparam int STRAY_LIMIT  = 4000;

	logic clk0;
	logic c10_resetn;
	logic rx;
	logic tx;
	logic capture_active;

	int          err_count;
	int          check_count;
	int          case_count;
	int          bytes_seen;
	bit          timed_out;

	capture_top #(
		.CLKS_PER_BIT(BIT_CLKS),
		.SAMPLES(SAMPLES),
		.GAP_CYCLES(GAP_CYCLES)
	) u_capture_top
	(
		.clk0(clk0), .c10_resetn(c10_resetn), .rx(rx),
		.tx(tx), .capture_active(capture_active)
	);

	// 100 ns clock
	initial
	begin
		clk0 = 1'b0;
		forever #50 clk0 = ~clk0;
	end

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
		check_count++;
		if (actual !== expected)
		begin
			err_count++;
			$display("** Error at %0t ns: %s expected %02h, got %02h",
				$time, name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected)
		begin
			err_count++;
			$display("** Error at %0t ns: %s expected %b, got %b",
				$time, name, expected, actual);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// uart line tasks
	//////////////////////////////////////////////////////////////////////

	// 8N1 onto rx with each bit set 10 ns after the edge
	task automatic send_byte(input byte_t data);
		logic [9:0] frame;
		int         k;
		frame = {1'b1, data, 1'b0};
		for (k = 0; k < 10; k++)
		begin
			@(posedge clk0);
			#10;
			rx = frame[k];
			repeat (BIT_CLKS - 1) @(posedge clk0);
		end
	endtask

	// mid-bit receive from tx sampled on falling edges
	task automatic recv_byte(output byte_t data);
		int    waited;
		int    k;
		byte_t shift;
		waited = 0;
		shift  = '0;
		data   = '0;
		@(negedge clk0);
		while (tx !== 1'b0 && waited < RX_LIMIT)
		begin
			@(negedge clk0);
			waited++;
		end
		if (tx !== 1'b0)
		begin
			$display("timeout: no start bit on tx within %0d cycles at %0t ns",
				RX_LIMIT, $time);
			timed_out = 1'b1;
			err_count++;
		end
		else
		begin
			// to the middle of the start bit
			repeat (BIT_CLKS / 2) @(negedge clk0);
			check_bit("tx start bit", 1'b0, tx);
			for (k = 0; k < 8; k++)
			begin
				repeat (BIT_CLKS) @(negedge clk0);
				shift[k] = tx;
			end
			repeat (BIT_CLKS) @(negedge clk0);
			check_bit("tx stop bit", 1'b1, tx);
			data = shift;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// one capture run
	//////////////////////////////////////////////////////////////////////

	task automatic run_case(input byte_t p, input byte_t exp_even, input byte_t exp_odd);
		int    errs_before;
		int    idle;
		int    waited;
		int    stray_wait;
		int    i;
		byte_t got;
		byte_t expected;
		string name;
		errs_before = err_count;
		bytes_seen  = 0;
		idle        = $urandom_range(20, 2);
		repeat (idle) @(posedge clk0);
		send_byte(p);
		fork
			// frame of param echo then the trace
			begin
				for (i = 0; i <= SAMPLES && !timed_out; i++)
				begin
					recv_byte(got);
					if (!timed_out)
					begin
						if (i == 0)
						begin
							name     = "frame param byte";
							expected = p;
						end
						else
						begin
							name     = $sformatf("trace byte %0d", i - 1);
							expected = ((i - 1) % 2 == 0) ? exp_even : exp_odd;
						end
						check_byte(name, expected, got);
						check_bit("capture_active", 1'b1, capture_active);
						bytes_seen++;
					end
				end
			end
			// stray byte on rx during the dump is ignored
			begin
				stray_wait = 0;
				while (bytes_seen < 2 && !timed_out && stray_wait < STRAY_LIMIT)
				begin
					@(posedge clk0);
					stray_wait++;
				end
				if (bytes_seen >= 2)
					send_byte(~p);
				else if (!timed_out)
				begin
					$display("timeout: dump never reached its second byte at %0t ns", $time);
					timed_out = 1'b1;
					err_count++;
				end
			end
		join
		if (!timed_out)
		begin
			waited = 0;
			while (capture_active !== 1'b0 && waited < DROP_LIMIT)
			begin
				@(negedge clk0);
				waited++;
			end
			check_bit("capture_active after frame", 1'b0, capture_active);
			// no extra frame may follow
			waited = 0;
			while (tx === 1'b1 && waited < QUIET_CYCLES)
			begin
				@(negedge clk0);
				waited++;
			end
			check_bit("tx after frame", 1'b1, tx);
		end
		case_count++;
		$display("case %0d  param %02h  %0d of %0d bytes  %s", case_count, p,
			bytes_seen, SAMPLES + 1, (err_count == errs_before) ? "ok" : "errors");
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int    fd;
		int    rc;
		string line;
		byte_t p;
		byte_t exp_even;
		byte_t exp_odd;
		rx          = 1'b1;
		c10_resetn  = 1'b0;
		err_count   = 0;
		check_count = 0;
		case_count  = 0;
		bytes_seen  = 0;
		timed_out   = 1'b0;
		void'($urandom(SEED));
		// reset for 3 cycles
		repeat (3) @(posedge clk0);
		#10;
		c10_resetn = 1'b1;
		@(negedge clk0);
		check_bit("tx after reset", 1'b1, tx);
		check_bit("capture_active after reset", 1'b0, capture_active);
		fd = $fopen("capture_cases.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open capture_cases.txt");
			err_count++;
		end
		else
		begin
			// back to back runs without reset in between
			while (!$feof(fd) && !timed_out)
			begin
				line = "";
				rc   = $fgets(line, fd);
				if (line.len() > 0 && line[0] != "#")
				begin
					rc = $sscanf(line, "%h %h %h", p, exp_even, exp_odd);
					if (rc == 3)
						run_case(p, exp_even, exp_odd);
				end
			end
			$fclose(fd);
			if (case_count == 0)
			begin
				$display("no cases found in capture_cases.txt");
				err_count++;
			end
		end
		$display("%0d cases, %0d checks, %0d errors", case_count, check_count, err_count);
		if (err_count == 0 && !timed_out)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* capture_cases.txt */
# param even odd, all hex
# even = sample with parity 0, odd = sample with parity 1
00 80 00
ff 00 80
01 00 01
80 07 00
7f 00 07
a5 00 01
5a 01 00
3c 02 00
c3 00 02
10 04 00
0f 00 04
e0 05 00
1f 00 05
40 06 00
3f 00 06
08 03 00
17 00 03
fe 01 00
02 01 00
fd 00 01
24 02 00
bf 00 06

/* compile.f */
capture_pkg.sv
uart_rx.sv
uart_tx.sv
carry_sensor.sv
trace_ram.sv
capture_ctrl.sv
capture_top.sv
capture_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module capture_tb -f compile.f
out=$(./obj_dir/Vcapture_tb)
echo "$out"
echo "$out" | grep -qx "All checks passed"
